// File: src/erx_consts.svh
`ifndef ERX_CONSTS_SVH
`define ERX_CONSTS_SVH

`default_nettype none

// Packet and address widths
`define ERX_PW 104
`define ERX_AW 32

// Node identity and the group that tags read responses
`define ERX_CHIP_ID 12'h800
`define ERX_GROUP_READTAG 4'h8

// Queue sizing and read watchdog
`define ERX_FIFO_DEPTH 4
`define ERX_TIMEOUT_CYCLES 64
`define ERX_FAULT_DATA 32'hDEADBEEF

`default_nettype wire

`endif

// File: src/erx_pkg.sv
`include "erx_consts.svh"

`default_nettype none

package erx_pkg;

  // ####################
  // Destination address
  // ####################

  // Mesh view of the address
  typedef struct packed {
    logic [11:0] chip_id;
    logic [3:0]  group;
    logic [15:0] offset;
  } erx_dst_t;

  // Remap stage reads it flat, sorter reads the mesh fields
  typedef union packed {
    logic [`ERX_AW-1:0] flat;
    erx_dst_t           fields;
  } erx_addr_t;

  // ####################
  // Link packet
  // ####################

  // Field order is the wire order, srcaddr in the top bits
  typedef struct packed {
    logic [`ERX_AW-1:0] srcaddr;
    logic [`ERX_AW-1:0] data;
    erx_addr_t          dstaddr;
    logic [3:0]         ctrlmode;
    logic [1:0]         datamode;
    logic               write;
    logic               access;
  } erx_packet_t;

endpackage

`default_nettype wire

// File: src/erx_remap.sv
`include "erx_consts.svh"

`default_nettype none

module erx_remap (
  input  logic                 clk,
  input  logic                 reset,
  // Link side
  input  logic                 erx_access,
  input  erx_pkg::erx_packet_t erx_packet,
  output logic                 erx_remap_wait,
  // Table configuration
  input  logic                 cfg_write,
  input  logic [3:0]           cfg_index,
  input  logic                 cfg_enable,
  input  logic [11:0]          cfg_chip_id,
  // Toward the sorter
  output logic                 emmu_access,
  output erx_pkg::erx_packet_t emmu_packet,
  input  logic                 emmu_wait
);

  import erx_pkg::*;

  logic [15:0] map_en;
  logic [11:0] map_id [16];
  logic [3:0]  map_idx;
  logic        load;
  erx_packet_t remapped;

  // ####################
  // Remap table
  // ####################

  // Enables come up cleared
  always_ff @(posedge clk) begin
    if (reset) begin
      map_en <= '0;
    end else if (cfg_write) begin
      map_en[cfg_index] <= cfg_enable;
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_write) begin
      map_id[cfg_index] <= cfg_chip_id;
    end
  end

  // Table slot picked by top nibble of flat address
  assign map_idx = erx_packet.dstaddr.flat[`ERX_AW-1:`ERX_AW-4];

  always_comb begin
    remapped = erx_packet;
    if (map_en[map_idx]) begin
      remapped.dstaddr.fields.chip_id = map_id[map_idx];
    end
  end

  // ####################
  // Output register
  // ####################

  // Single slot, so link stalls whenever sorter stalls
  assign erx_remap_wait = emmu_wait;
  assign load           = erx_access & ~erx_remap_wait;

  // Held while sorter waits, refilled as it drains
  always_ff @(posedge clk) begin
    if (reset) begin
      emmu_access <= 1'b0;
    end else if (!emmu_wait) begin
      emmu_access <= erx_access;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      emmu_packet <= remapped;
    end
  end

endmodule

`default_nettype wire

// File: src/erx_disty.sv
`include "erx_consts.svh"

`default_nettype none

module erx_disty (
  // Raw link input
  input  logic                 erx_access,
  input  erx_pkg::erx_packet_t erx_packet,
  output logic                 erx_wait,
  // Remapped link input
  input  logic                 emmu_access,
  input  erx_pkg::erx_packet_t emmu_packet,
  output logic                 emmu_wait,
  // DMA input
  input  logic                 edma_access,
  input  erx_pkg::erx_packet_t edma_packet,
  output logic                 edma_wait,
  // Master write queue
  output logic                 rxwr_fifo_access,
  output erx_pkg::erx_packet_t rxwr_fifo_packet,
  input  logic                 rxwr_fifo_wait,
  // Master read queue
  output logic                 rxrd_fifo_access,
  output erx_pkg::erx_packet_t rxrd_fifo_packet,
  input  logic                 rxrd_fifo_wait,
  // Read response queue
  output logic                 rxrr_fifo_access,
  output erx_pkg::erx_packet_t rxrr_fifo_packet,
  input  logic                 rxrr_fifo_wait,
  // Watchdog expiry
  input  logic                 timeout
);

  import erx_pkg::*;

  logic        rx_rd_wait;
  logic        rx_wr_wait;
  logic        emmu_read;
  logic        emmu_go;
  logic        erx_rresp;
  erx_packet_t fault_packet;

  // ####################
  // Wait generation
  // ####################

  assign rx_rd_wait = rxrd_fifo_wait;
  assign rx_wr_wait = rxwr_fifo_wait | rxrr_fifo_wait;
  // Timeout owns the response queue for its cycle
  assign erx_wait   = rx_rd_wait | rx_wr_wait | timeout;
  assign emmu_wait  = erx_wait;
  assign emmu_go    = emmu_access & ~emmu_wait;
  assign emmu_read  = emmu_access & ~emmu_packet.write;
  // Remapped read blocks DMA even while stalled
  assign edma_wait  = rxrd_fifo_wait | emmu_read;

  // ####################
  // Read response path
  // ####################

  // Own chip id plus read-tag group marks a response
  assign erx_rresp = erx_access & ~erx_wait & erx_packet.write &
                     (erx_packet.dstaddr.fields.chip_id == `ERX_CHIP_ID) &
                     (erx_packet.dstaddr.fields.group == `ERX_GROUP_READTAG);

  always_comb begin
    fault_packet                        = '0;
    fault_packet.data                   = `ERX_FAULT_DATA;
    fault_packet.dstaddr.fields.chip_id = `ERX_CHIP_ID;
    fault_packet.dstaddr.fields.group   = `ERX_GROUP_READTAG;
    fault_packet.write                  = 1'b1;
    fault_packet.access                 = 1'b1;
  end

  assign rxrr_fifo_access = timeout | erx_rresp;
  assign rxrr_fifo_packet = timeout ? fault_packet : erx_packet;

  // ####################
  // Write and read paths
  // ####################

  // Writes to own id are responses, handled raw above
  assign rxwr_fifo_access = emmu_go & emmu_packet.write &
                            (emmu_packet.dstaddr.fields.chip_id != `ERX_CHIP_ID);
  assign rxwr_fifo_packet = emmu_packet;

  // Remapped read first, DMA fills the gaps
  assign rxrd_fifo_access = (emmu_go & ~emmu_packet.write) | (edma_access & ~edma_wait);
  assign rxrd_fifo_packet = emmu_read ? emmu_packet : edma_packet;

endmodule

`default_nettype wire

// File: src/erx_fifo.sv
`include "erx_consts.svh"

`default_nettype none

module erx_fifo #(
  parameter int DEPTH = `ERX_FIFO_DEPTH
) (
  input  logic                 clk,
  input  logic                 reset,
  // Write side
  input  logic                 in_access,
  input  erx_pkg::erx_packet_t in_packet,
  output logic                 in_wait,
  // Read side, head always visible
  output logic                 out_access,
  output erx_pkg::erx_packet_t out_packet,
  input  logic                 out_wait
);

  import erx_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  erx_packet_t      mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Full flag is the upstream stall
  assign in_wait    = (count == CNT_W'(DEPTH));
  assign out_access = (count != '0);
  assign out_packet = mem[rd_ptr];

  assign push = in_access & ~in_wait;
  assign pop  = out_access & ~out_wait;

  // ####################
  // Storage
  // ####################

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_packet;
    end
  end

  // Pointers wrap at DEPTH, any size works
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/erx_watchdog.sv
`include "erx_consts.svh"

`default_nettype none

module erx_watchdog (
  input  logic clk,
  input  logic reset,
  // Read queue output handshake
  input  logic rxrd_access,
  input  logic rxrd_packet_write,
  input  logic rxrd_wait,
  // Response queue output handshake
  input  logic rxrr_access,
  input  logic rxrr_wait,
  output logic timeout
);

  localparam int CW = $clog2(`ERX_TIMEOUT_CYCLES + 1);

  logic          armed;
  logic [CW-1:0] count;
  logic          rd_issued;
  logic          rr_seen;

  assign rd_issued = rxrd_access & ~rxrd_wait & ~rxrd_packet_write;
  assign rr_seen   = rxrr_access & ~rxrr_wait;

  // Fresh read restarts the timer, any response disarms it
  always_ff @(posedge clk) begin
    if (reset) begin
      armed   <= 1'b0;
      count   <= '0;
      timeout <= 1'b0;
    end else begin
      timeout <= 1'b0;
      if (rd_issued) begin
        armed <= 1'b1;
        count <= '0;
      end else if (rr_seen) begin
        armed <= 1'b0;
        count <= '0;
      end else if (armed) begin
        if (count == CW'(`ERX_TIMEOUT_CYCLES - 1)) begin
          // Expired, pulse once then go idle
          armed   <= 1'b0;
          count   <= '0;
          timeout <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/erx_core.sv
`default_nettype none

module erx_core (
  input  logic                 clk,
  input  logic                 reset,
  // Link input
  input  logic                 erx_access,
  input  erx_pkg::erx_packet_t erx_packet,
  output logic                 erx_wait,
  // DMA input
  input  logic                 edma_access,
  input  erx_pkg::erx_packet_t edma_packet,
  output logic                 edma_wait,
  // Remap table writes
  input  logic                 cfg_write,
  input  logic [3:0]           cfg_index,
  input  logic                 cfg_enable,
  input  logic [11:0]          cfg_chip_id,
  // Master write stream
  output logic                 rxwr_access,
  output erx_pkg::erx_packet_t rxwr_packet,
  input  logic                 rxwr_wait,
  // Master read stream
  output logic                 rxrd_access,
  output erx_pkg::erx_packet_t rxrd_packet,
  input  logic                 rxrd_wait,
  // Read response stream
  output logic                 rxrr_access,
  output erx_pkg::erx_packet_t rxrr_packet,
  input  logic                 rxrr_wait
);

  import erx_pkg::*;

  logic        emmu_access, emmu_wait, disty_wait, timeout;
  erx_packet_t emmu_packet;
  logic        rxwr_fifo_access, rxrd_fifo_access, rxrr_fifo_access;
  logic        rxwr_fifo_wait, rxrd_fifo_wait, rxrr_fifo_wait;
  erx_packet_t rxwr_fifo_packet, rxrd_fifo_packet, rxrr_fifo_packet;

  // Sorter wait stalls link and remap stage alike
  assign erx_wait = disty_wait;

  erx_remap remap0 (
    .clk, .reset, .erx_access, .erx_packet, .erx_remap_wait(),
    .cfg_write, .cfg_index, .cfg_enable, .cfg_chip_id,
    .emmu_access, .emmu_packet, .emmu_wait
  );

  erx_disty disty0 (
    .erx_access, .erx_packet, .erx_wait(disty_wait),
    .emmu_access, .emmu_packet, .emmu_wait,
    .edma_access, .edma_packet, .edma_wait,
    .rxwr_fifo_access, .rxwr_fifo_packet, .rxwr_fifo_wait,
    .rxrd_fifo_access, .rxrd_fifo_packet, .rxrd_fifo_wait,
    .rxrr_fifo_access, .rxrr_fifo_packet, .rxrr_fifo_wait, .timeout
  );

  // ####################
  // Output queues
  // ####################

  erx_fifo wr_fifo0 (
    .clk, .reset, .in_access(rxwr_fifo_access), .in_packet(rxwr_fifo_packet),
    .in_wait(rxwr_fifo_wait), .out_access(rxwr_access), .out_packet(rxwr_packet),
    .out_wait(rxwr_wait)
  );

  erx_fifo rd_fifo0 (
    .clk, .reset, .in_access(rxrd_fifo_access), .in_packet(rxrd_fifo_packet),
    .in_wait(rxrd_fifo_wait), .out_access(rxrd_access), .out_packet(rxrd_packet),
    .out_wait(rxrd_wait)
  );

  erx_fifo rr_fifo0 (
    .clk, .reset, .in_access(rxrr_fifo_access), .in_packet(rxrr_fifo_packet),
    .in_wait(rxrr_fifo_wait), .out_access(rxrr_access), .out_packet(rxrr_packet),
    .out_wait(rxrr_wait)
  );

  // Watches outgoing reads against returning responses
  erx_watchdog wdog0 (
    .clk, .reset, .rxrd_access, .rxrd_packet_write(rxrd_packet.write), .rxrd_wait,
    .rxrr_access, .rxrr_wait, .timeout
  );

endmodule

`default_nettype wire

// File: verif/erx_tb.sv
`include "erx_consts.svh"

`default_nettype none

module erx_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import erx_pkg::*;

  // Stream numbers, NONE means the packet is dropped
  localparam int WR = 0;
  localparam int RD = 1;
  localparam int RR = 2;
  localparam int NONE = 3;

  logic        clk = 1'b0;
  logic        reset, erx_access, edma_access, cfg_write, cfg_enable;
  logic [3:0]  cfg_index;
  logic [11:0] cfg_chip_id;
  logic [2:0]  out_wait;
  logic        erx_wait, edma_wait, rand_on;
  wire  [2:0]  out_access;
  erx_packet_t erx_packet, edma_packet, wr_pkt, rd_pkt, rr_pkt;
  int          seed = 32'hef03;

  // Stimulus table, one row per input packet
  string       t_name [32];
  bit          t_dma [32], t_write [32], t_blk [32];
  logic [31:0] t_dst [32], t_xdst [32];
  int          t_strm [32];
  int          nrow = 0;

  // Model queues per output stream
  erx_packet_t exp_pkt [3][64];
  string       exp_name [3][64];
  int          head [3] = '{0, 0, 0};
  int          tail [3] = '{0, 0, 0};

  erx_core dut0 (
    .clk, .reset, .erx_access, .erx_packet, .erx_wait, .edma_access, .edma_packet,
    .edma_wait, .cfg_write, .cfg_index, .cfg_enable, .cfg_chip_id,
    .rxwr_access(out_access[WR]), .rxwr_packet(wr_pkt), .rxwr_wait(out_wait[WR]),
    .rxrd_access(out_access[RD]), .rxrd_packet(rd_pkt), .rxrd_wait(out_wait[RD]),
    .rxrr_access(out_access[RR]), .rxrr_packet(rr_pkt), .rxrr_wait(out_wait[RR])
  );

  always #2 clk = ~clk;

  // Output stalls, random only during the burst
  always @(posedge clk) begin
    out_wait <= #0.5 rand_on ? 3'($random(seed)) : 3'b000;
  end

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check(string name, logic [103:0] exp, logic [103:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic add_row(string name, bit dma, bit wr, logic [31:0] dst, int strm,
                         logic [31:0] xdst, bit blk);
    t_name[nrow] = name;
    t_dma[nrow] = dma;
    t_write[nrow] = wr;
    t_dst[nrow] = dst;
    t_strm[nrow] = strm;
    t_xdst[nrow] = xdst;
    t_blk[nrow] = blk;
    nrow++;
  endtask

  task automatic expect_pkt(int s, string name, erx_packet_t p);
    exp_pkt[s][tail[s]] = p;
    exp_name[s][tail[s]] = name;
    tail[s]++;
  endtask

  function automatic erx_packet_t pick(int s);
    case (s)
      WR: return wr_pkt;
      RD: return rd_pkt;
      default: return rr_pkt;
    endcase
  endfunction

  function automatic erx_packet_t make_pkt(int i);
    erx_packet_t p;
    p = '0;
    p.srcaddr = 32'h5000_0000 + i;
    p.data = 32'hd00d_0000 + i;
    p.dstaddr.flat = t_dst[i];
    p.datamode = 2'b10;
    p.write = t_write[i];
    p.access = 1'b1;
    return p;
  endfunction

  // Fault response: own id, read-tag group, zero offset
  function automatic erx_packet_t fault_pkt();
    erx_packet_t p;
    p = '0;
    p.data = `ERX_FAULT_DATA;
    p.dstaddr.flat = {`ERX_CHIP_ID, `ERX_GROUP_READTAG, 16'h0000};
    p.write = 1'b1;
    p.access = 1'b1;
    return p;
  endfunction

  // ####################
  // Driver
  // ####################

  task automatic send(int i);
    erx_packet_t p;
    erx_packet_t x;
    int n;
    p = make_pkt(i);
    x = p;
    x.dstaddr.flat = t_xdst[i];
    if (t_strm[i] != NONE) begin
      expect_pkt(t_strm[i], t_name[i], x);
    end
    if (t_dma[i]) begin
      edma_access = 1'b1;
      edma_packet = p;
    end else begin
      erx_access = 1'b1;
      erx_packet = p;
    end
    n = 0;
    do begin
      @(posedge clk);
      // DMA must see the remapped read ahead of it
      if (n == 0 && t_blk[i]) begin
        check({t_name[i], "_blocked"}, 1, edma_wait);
      end
      n++;
      if (n > 200) begin
        $display("Timeout: %s was never accepted at the input", t_name[i]);
        stop_run();
      end
    end while (t_dma[i] ? edma_wait : erx_wait);
    #0.5;
    erx_access = 1'b0;
    edma_access = 1'b0;
  endtask

  task automatic run_rows(int first, int last);
    for (int i = first; i <= last; i++) begin
      send(i);
    end
  endtask

  // Wait until every model queue is empty
  task automatic drain(int limit);
    int n;
    n = 0;
    while (head[WR] != tail[WR] || head[RD] != tail[RD] || head[RR] != tail[RR]) begin
      @(posedge clk);
      #0.5;
      n++;
      if (n > limit) begin
        $display("Timeout: expected output packets did not arrive");
        stop_run();
      end
    end
  endtask

  // ####################
  // Monitors
  // ####################

  always @(posedge clk) begin
    if (!reset) begin
      for (int s = 0; s < 3; s++) begin
        if (out_access[s] && !out_wait[s]) begin
          if (head[s] == tail[s]) begin
            $display("Unexpected packet on output stream %0d", s);
            stop_run();
          end else begin
            check(exp_name[s][head[s]], exp_pkt[s][head[s]], pick(s));
            head[s]++;
          end
        end
      end
    end
  end

  initial begin
    reset = 1'b1;
    erx_access = 1'b0;
    edma_access = 1'b0;
    erx_packet = '0;
    edma_packet = '0;
    cfg_write = 1'b0;
    cfg_index = '0;
    cfg_enable = 1'b0;
    cfg_chip_id = '0;
    out_wait = '0;
    rand_on = 1'b0;
    // Rows 0 to 6, remap and routing
    add_row("remap_wr", 0, 1, 32'h3000_0040, WR, 32'h1230_0040, 0);
    add_row("pass_wr", 0, 1, 32'h5550_0010, WR, 32'h5550_0010, 0);
    add_row("remap_rd", 0, 0, 32'h3abc_0000, RD, 32'h123c_0000, 0);
    add_row("link_rd", 0, 0, 32'h2220_0100, RD, 32'h2220_0100, 0);
    add_row("dma_rd", 1, 0, 32'h7770_0200, RD, 32'h7770_0200, 1);
    add_row("rresp", 0, 1, 32'h8008_0004, RR, 32'h8008_0004, 0);
    add_row("own_other", 0, 1, 32'h8003_0008, NONE, 32'h8003_0008, 0);
    // Rows 7 to 26, mixed burst
    for (int k = 0; k < 20; k++) begin
      case (k % 4)
        0: add_row("burst_wr", 0, 1, 32'h4010_0000 + k, WR, 32'h4010_0000 + k, 0);
        1: add_row("burst_rd", 0, 0, 32'h6020_0000 + k, RD, 32'h6020_0000 + k, 0);
        2: add_row("burst_rr", 0, 1, 32'h8008_0000 + k, RR, 32'h8008_0000 + k, 0);
        default: add_row("burst_dma", 1, 0, 32'h9030_0000 + k, RD, 32'h9030_0000 + k, 0);
      endcase
    end
    // Row 27 disarms the watchdog, rows 28 to 30 exercise it
    add_row("burst_clr", 0, 1, 32'h8008_00ff, RR, 32'h8008_00ff, 0);
    add_row("wd_read", 0, 0, 32'h2220_0300, RD, 32'h2220_0300, 0);
    add_row("wd_read2", 0, 0, 32'h2220_0400, RD, 32'h2220_0400, 0);
    add_row("wd_resp", 0, 1, 32'h8008_0400, RR, 32'h8008_0400, 0);

    repeat (2) @(posedge clk);
    #0.5;
    reset = 1'b0;
    // Entry 3 maps to chip 0x123
    cfg_write = 1'b1;
    cfg_index = 4'd3;
    cfg_enable = 1'b1;
    cfg_chip_id = 12'h123;
    @(posedge clk);
    #0.5;
    cfg_write = 1'b0;
    run_rows(0, 6);
    drain(50);
    rand_on = 1'b1;
    run_rows(7, 26);
    drain(300);
    rand_on = 1'b0;
    run_rows(27, 27);
    drain(50);
    // Unanswered read, fault response expected
    run_rows(28, 28);
    expect_pkt(RR, "wd_fault", fault_pkt());
    drain(`ERX_TIMEOUT_CYCLES + 20);
    // Answered read, monitor flags any late fault
    run_rows(29, 29);
    drain(20);
    run_rows(30, 30);
    drain(20);
    repeat (`ERX_TIMEOUT_CYCLES + 20) @(posedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/erx_pkg.sv
src/erx_remap.sv
src/erx_disty.sv
src/erx_fifo.sv
src/erx_watchdog.sv
src/erx_core.sv
verif/erx_tb.sv
